//--- verilog/cpuCfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and instruction word width
`define CPU_DATA_W      32

// Memory sizes in words
`define CPU_IMEM_DEPTH  256
`define CPU_DMEM_DEPTH  256

// Register file geometry
`define CPU_REG_COUNT   32
`define CPU_REG_ADDR_W  5

`endif

//--- verilog/isaPkg.sv
`include "cpuCfg.svh"

package isaPkg;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_t;

    typedef struct packed {
        opcode_t                    opcode;
        logic [`CPU_REG_ADDR_W-1:0] rs;
        logic [`CPU_REG_ADDR_W-1:0] rt;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_REG_ADDR_W-1:0] shamt;
        funct_t                     funct;
    } rType_t;

    typedef struct packed {
        opcode_t                    opcode;
        logic [`CPU_REG_ADDR_W-1:0] rs;
        logic [`CPU_REG_ADDR_W-1:0] rt;
        logic [15:0]                imm;
    } iType_t;

    // Same word seen through either format
    typedef union packed {
        rType_t r;
        iType_t i;
    } instr_t;

    localparam instr_t NOP = '0;

endpackage

//--- verilog/pipePkg.sv
package pipePkg;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } aluOp_t;

    // Where ALU control takes the operation from
    typedef enum logic [1:0] {
        CLS_MEM,     // Address add for lw/sw
        CLS_BRANCH,  // Subtract for beq compare
        CLS_FUNCT,   // R-type funct field
        CLS_IMM      // addi
    } aluClass_t;

endpackage

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  isaPkg::opcode_t     i_opcode,
    output logic                o_regDst,
    output logic                o_aluSrc,
    output pipePkg::aluClass_t  o_aluClass,
    output logic                o_branch,
    output logic                o_memRead,
    output logic                o_memWrite,
    output logic                o_memToReg,
    output logic                o_regWrite
);

    always_comb begin
        // Unknown opcodes fall through as a NOP
        o_regDst   = 1'b0;
        o_aluSrc   = 1'b0;
        o_aluClass = pipePkg::CLS_MEM;
        o_branch   = 1'b0;
        o_memRead  = 1'b0;
        o_memWrite = 1'b0;
        o_memToReg = 1'b0;
        o_regWrite = 1'b0;
        case (i_opcode)
            isaPkg::OP_RTYPE: begin
                o_regDst   = 1'b1;
                o_aluClass = pipePkg::CLS_FUNCT;
                o_regWrite = 1'b1;
            end
            isaPkg::OP_ADDI: begin
                o_aluSrc   = 1'b1;
                o_aluClass = pipePkg::CLS_IMM;
                o_regWrite = 1'b1;
            end
            isaPkg::OP_LW: begin
                o_aluSrc   = 1'b1;
                o_memRead  = 1'b1;
                o_memToReg = 1'b1;
                o_regWrite = 1'b1;
            end
            isaPkg::OP_SW: begin
                o_aluSrc   = 1'b1;
                o_memWrite = 1'b1;
            end
            isaPkg::OP_BEQ: begin
                o_aluClass = pipePkg::CLS_BRANCH;
                o_branch   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/fetchStage.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module fetchStage (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_imemWrite,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  i_imemAddr,
    input  isaPkg::instr_t                      i_imemData,
    input  logic                                i_branchTaken,
    input  logic [`CPU_DATA_W-1:0]              i_branchTarget,
    output isaPkg::instr_t                      o_instr,
    output logic [`CPU_DATA_W-1:0]              o_pcPlus4
);
    localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

    isaPkg::instr_t         imem [`CPU_IMEM_DEPTH];
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] pcPlus4;
    logic [`CPU_DATA_W-1:0] nextPc;

    // Program load port, only live while the core is held in reset
    always_ff @(posedge i_clk) begin
        if (i_reset && i_imemWrite) begin
            imem[i_imemAddr] <= i_imemData;
        end
    end

    assign pcPlus4 = pc + `CPU_DATA_W'(4);

    // Taken beq from MEM overrides sequential fetch
    assign nextPc = i_branchTaken ? i_branchTarget : pcPlus4;

    ////////////////////////////////////////
    // PC and IF/ID register
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc        <= '0;
            o_instr   <= isaPkg::NOP;
            o_pcPlus4 <= '0;
        end else begin
            pc        <= nextPc;
            o_instr   <= imem[pc[IMEM_AW+1:2]];
            o_pcPlus4 <= pcPlus4;
        end
    end

    loadOnlyInReset: assert property (@(posedge i_clk) i_imemWrite |-> i_reset);

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module decodeStage (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  isaPkg::instr_t                      i_instr,
    input  logic [`CPU_DATA_W-1:0]              i_pcPlus4,
    input  logic                                i_wbValid,
    input  logic [`CPU_REG_ADDR_W-1:0]          i_wbReg,
    input  logic [`CPU_DATA_W-1:0]              i_wbData,
    output logic [`CPU_DATA_W-1:0]              o_rsData,
    output logic [`CPU_DATA_W-1:0]              o_rtData,
    output logic [`CPU_DATA_W-1:0]              o_imm,
    output logic [`CPU_REG_ADDR_W-1:0]          o_rt,
    output logic [`CPU_REG_ADDR_W-1:0]          o_rd,
    output logic [`CPU_REG_ADDR_W-1:0]          o_shamt,
    output isaPkg::funct_t                      o_funct,
    output logic [`CPU_DATA_W-1:0]              o_pcPlus4,
    output logic                                o_regDst,
    output logic                                o_aluSrc,
    output pipePkg::aluClass_t                  o_aluClass,
    output logic                                o_branch,
    output logic                                o_memRead,
    output logic                                o_memWrite,
    output logic                                o_memToReg,
    output logic                                o_regWrite
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];
    logic [`CPU_DATA_W-1:0] rsData;
    logic [`CPU_DATA_W-1:0] rtData;
    logic [`CPU_DATA_W-1:0] immExt;
    logic                   regDst;
    logic                   aluSrc;
    pipePkg::aluClass_t     aluClass;
    logic                   branch;
    logic                   memRead;
    logic                   memWrite;
    logic                   memToReg;
    logic                   regWrite;
    logic                   isNop;

    controlUnit u_controlUnit (
        .i_opcode   (i_instr.r.opcode),
        .o_regDst   (regDst),
        .o_aluSrc   (aluSrc),
        .o_aluClass (aluClass),
        .o_branch   (branch),
        .o_memRead  (memRead),
        .o_memWrite (memWrite),
        .o_memToReg (memToReg),
        .o_regWrite (regWrite)
    );

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_wbValid && i_wbReg != '0) begin
            regs[i_wbReg] <= i_wbData;
        end
    end

    // r0 is hardwired, same-cycle writeback passes straight through
    function automatic logic [`CPU_DATA_W-1:0] readReg(input logic [`CPU_REG_ADDR_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_wbValid && i_wbReg == idx) begin
            return i_wbData;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rsData = readReg(i_instr.r.rs);
        rtData = readReg(i_instr.r.rt);
    end

    assign immExt = {{(`CPU_DATA_W-16){i_instr.i.imm[15]}}, i_instr.i.imm};

    // All-zero word is a bubble with no control
    assign isNop = (i_instr == isaPkg::NOP);

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        o_rsData  <= rsData;
        o_rtData  <= rtData;
        o_imm     <= immExt;
        o_rt      <= i_instr.i.rt;
        o_rd      <= i_instr.r.rd;
        o_shamt   <= i_instr.r.shamt;
        o_funct   <= i_instr.r.funct;
        o_pcPlus4 <= i_pcPlus4;
        if (i_reset || isNop) begin
            o_regDst   <= 1'b0;
            o_aluSrc   <= 1'b0;
            o_aluClass <= pipePkg::CLS_MEM;
            o_branch   <= 1'b0;
            o_memRead  <= 1'b0;
            o_memWrite <= 1'b0;
            o_memToReg <= 1'b0;
            o_regWrite <= 1'b0;
        end else begin
            o_regDst   <= regDst;
            o_aluSrc   <= aluSrc;
            o_aluClass <= aluClass;
            o_branch   <= branch;
            o_memRead  <= memRead;
            o_memWrite <= memWrite;
            o_memToReg <= memToReg;
            o_regWrite <= regWrite;
        end
    end

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module executeStage (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic [`CPU_DATA_W-1:0]              i_rsData,
    input  logic [`CPU_DATA_W-1:0]              i_rtData,
    input  logic [`CPU_DATA_W-1:0]              i_imm,
    input  logic [`CPU_REG_ADDR_W-1:0]          i_rt,
    input  logic [`CPU_REG_ADDR_W-1:0]          i_rd,
    input  logic [`CPU_REG_ADDR_W-1:0]          i_shamt,
    input  isaPkg::funct_t                      i_funct,
    input  logic [`CPU_DATA_W-1:0]              i_pcPlus4,
    input  logic                                i_regDst,
    input  logic                                i_aluSrc,
    input  pipePkg::aluClass_t                  i_aluClass,
    input  logic                                i_branch,
    input  logic                                i_memRead,
    input  logic                                i_memWrite,
    input  logic                                i_memToReg,
    input  logic                                i_regWrite,
    output logic [`CPU_DATA_W-1:0]              o_aluResult,
    output logic                                o_zero,
    output logic [`CPU_DATA_W-1:0]              o_branchTarget,
    output logic [`CPU_DATA_W-1:0]              o_storeData,
    output logic [`CPU_REG_ADDR_W-1:0]          o_destReg,
    output logic                                o_branch,
    output logic                                o_memRead,
    output logic                                o_memWrite,
    output logic                                o_memToReg,
    output logic                                o_regWrite
);

    pipePkg::aluOp_t            aluOp;
    logic [`CPU_DATA_W-1:0]     opB;
    logic [`CPU_DATA_W-1:0]     aluResult;
    logic [`CPU_DATA_W-1:0]     branchTarget;
    logic [`CPU_REG_ADDR_W-1:0] destReg;

    // ALU control
    always_comb begin
        aluOp = pipePkg::ALU_ADD;
        case (i_aluClass)
            pipePkg::CLS_BRANCH: aluOp = pipePkg::ALU_SUB;
            pipePkg::CLS_FUNCT: begin
                case (i_funct)
                    isaPkg::FN_SUB: aluOp = pipePkg::ALU_SUB;
                    isaPkg::FN_AND: aluOp = pipePkg::ALU_AND;
                    isaPkg::FN_OR:  aluOp = pipePkg::ALU_OR;
                    isaPkg::FN_SLT: aluOp = pipePkg::ALU_SLT;
                    isaPkg::FN_SLL: aluOp = pipePkg::ALU_SLL;
                    default:        aluOp = pipePkg::ALU_ADD;
                endcase
            end
            default: aluOp = pipePkg::ALU_ADD;
        endcase
    end

    assign opB = i_aluSrc ? i_imm : i_rtData;

    always_comb begin
        case (aluOp)
            pipePkg::ALU_SUB: aluResult = i_rsData - opB;
            pipePkg::ALU_AND: aluResult = i_rsData & opB;
            pipePkg::ALU_OR:  aluResult = i_rsData | opB;
            pipePkg::ALU_SLT: aluResult = `CPU_DATA_W'($signed(i_rsData) < $signed(opB));
            pipePkg::ALU_SLL: aluResult = opB << i_shamt;
            default:          aluResult = i_rsData + opB;
        endcase
    end

    // Word offset relative to the delay slot
    assign branchTarget = i_pcPlus4 + {i_imm[`CPU_DATA_W-3:0], 2'b00};
    assign destReg      = i_regDst ? i_rd : i_rt;

    ////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        o_aluResult    <= aluResult;
        o_zero         <= (aluResult == '0);
        o_branchTarget <= branchTarget;
        o_storeData    <= i_rtData;
        o_destReg      <= destReg;
        if (i_reset) begin
            o_branch   <= 1'b0;
            o_memRead  <= 1'b0;
            o_memWrite <= 1'b0;
            o_memToReg <= 1'b0;
            o_regWrite <= 1'b0;
        end else begin
            o_branch   <= i_branch;
            o_memRead  <= i_memRead;
            o_memWrite <= i_memWrite;
            o_memToReg <= i_memToReg;
            o_regWrite <= i_regWrite;
        end
    end

endmodule

//--- verilog/memWbStage.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module memWbStage (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic [`CPU_DATA_W-1:0]              i_aluResult,
    input  logic                                i_zero,
    input  logic [`CPU_DATA_W-1:0]              i_branchTarget,
    input  logic [`CPU_DATA_W-1:0]              i_storeData,
    input  logic [`CPU_REG_ADDR_W-1:0]          i_destReg,
    input  logic                                i_branch,
    input  logic                                i_memRead,
    input  logic                                i_memWrite,
    input  logic                                i_memToReg,
    input  logic                                i_regWrite,
    output logic                                o_branchTaken,
    output logic [`CPU_DATA_W-1:0]              o_branchTarget,
    output logic                                o_wbValid,
    output logic [`CPU_REG_ADDR_W-1:0]          o_wbReg,
    output logic [`CPU_DATA_W-1:0]              o_wbData
);
    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    logic [`CPU_DATA_W-1:0] dmem [`CPU_DMEM_DEPTH];
    logic [DMEM_AW-1:0]     dmemAddr;
    logic [`CPU_DATA_W-1:0] memData;
    logic [`CPU_DATA_W-1:0] wbAlu;
    logic [`CPU_DATA_W-1:0] wbMem;
    logic                   wbMemToReg;

    // beq decision goes back to fetch
    assign o_branchTaken  = i_branch && i_zero;
    assign o_branchTarget = i_branchTarget;

    ////////////////////////////////////////
    // Data memory, word addressed
    ////////////////////////////////////////
    assign dmemAddr = i_aluResult[DMEM_AW+1:2];
    assign memData  = dmem[dmemAddr];

    always_ff @(posedge i_clk) begin
        if (i_memWrite) begin
            dmem[dmemAddr] <= i_storeData;
        end
    end

    // MEM/WB register
    always_ff @(posedge i_clk) begin
        o_wbReg <= i_destReg;
        wbAlu   <= i_aluResult;
        wbMem   <= memData;
        if (i_reset) begin
            o_wbValid  <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            o_wbValid  <= i_regWrite;
            wbMemToReg <= i_memToReg;
        end
    end

    assign o_wbData = wbMemToReg ? wbMem : wbAlu;

    wordAligned: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_memRead || i_memWrite) |-> (i_aluResult[1:0] == 2'b00));

endmodule

//--- verilog/pipelineCpu.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module pipelineCpu (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_imemWrite,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  i_imemAddr,
    input  isaPkg::instr_t                      i_imemData,
    output logic                                o_wbValid,
    output logic [`CPU_REG_ADDR_W-1:0]          o_wbReg,
    output logic [`CPU_DATA_W-1:0]              o_wbData
);

    // IF/ID
    isaPkg::instr_t             ifIdInstr;
    logic [`CPU_DATA_W-1:0]     ifIdPcPlus4;
    // ID/EX
    logic [`CPU_DATA_W-1:0]     idExRsData, idExRtData, idExImm, idExPcPlus4;
    logic [`CPU_REG_ADDR_W-1:0] idExRt, idExRd, idExShamt;
    isaPkg::funct_t             idExFunct;
    pipePkg::aluClass_t         idExAluClass;
    logic                       idExRegDst, idExAluSrc, idExBranch;
    logic                       idExMemRead, idExMemWrite, idExMemToReg, idExRegWrite;
    // EX/MEM
    logic [`CPU_DATA_W-1:0]     exMemAluResult, exMemBranchTarget, exMemStoreData;
    logic [`CPU_REG_ADDR_W-1:0] exMemDestReg;
    logic                       exMemZero, exMemBranch;
    logic                       exMemMemRead, exMemMemWrite, exMemMemToReg, exMemRegWrite;
    // Feedback to fetch
    logic                       branchTaken;
    logic [`CPU_DATA_W-1:0]     branchTarget;

    fetchStage u_fetchStage (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_imemWrite    (i_imemWrite),
        .i_imemAddr     (i_imemAddr),
        .i_imemData     (i_imemData),
        .i_branchTaken  (branchTaken),
        .i_branchTarget (branchTarget),
        .o_instr        (ifIdInstr),
        .o_pcPlus4      (ifIdPcPlus4)
    );

    decodeStage u_decodeStage (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_instr    (ifIdInstr),
        .i_pcPlus4  (ifIdPcPlus4),
        .i_wbValid  (o_wbValid),
        .i_wbReg    (o_wbReg),
        .i_wbData   (o_wbData),
        .o_rsData   (idExRsData),
        .o_rtData   (idExRtData),
        .o_imm      (idExImm),
        .o_rt       (idExRt),
        .o_rd       (idExRd),
        .o_shamt    (idExShamt),
        .o_funct    (idExFunct),
        .o_pcPlus4  (idExPcPlus4),
        .o_regDst   (idExRegDst),
        .o_aluSrc   (idExAluSrc),
        .o_aluClass (idExAluClass),
        .o_branch   (idExBranch),
        .o_memRead  (idExMemRead),
        .o_memWrite (idExMemWrite),
        .o_memToReg (idExMemToReg),
        .o_regWrite (idExRegWrite)
    );

    executeStage u_executeStage (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rsData       (idExRsData),
        .i_rtData       (idExRtData),
        .i_imm          (idExImm),
        .i_rt           (idExRt),
        .i_rd           (idExRd),
        .i_shamt        (idExShamt),
        .i_funct        (idExFunct),
        .i_pcPlus4      (idExPcPlus4),
        .i_regDst       (idExRegDst),
        .i_aluSrc       (idExAluSrc),
        .i_aluClass     (idExAluClass),
        .i_branch       (idExBranch),
        .i_memRead      (idExMemRead),
        .i_memWrite     (idExMemWrite),
        .i_memToReg     (idExMemToReg),
        .i_regWrite     (idExRegWrite),
        .o_aluResult    (exMemAluResult),
        .o_zero         (exMemZero),
        .o_branchTarget (exMemBranchTarget),
        .o_storeData    (exMemStoreData),
        .o_destReg      (exMemDestReg),
        .o_branch       (exMemBranch),
        .o_memRead      (exMemMemRead),
        .o_memWrite     (exMemMemWrite),
        .o_memToReg     (exMemMemToReg),
        .o_regWrite     (exMemRegWrite)
    );

    memWbStage u_memWbStage (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_aluResult    (exMemAluResult),
        .i_zero         (exMemZero),
        .i_branchTarget (exMemBranchTarget),
        .i_storeData    (exMemStoreData),
        .i_destReg      (exMemDestReg),
        .i_branch       (exMemBranch),
        .i_memRead      (exMemMemRead),
        .i_memWrite     (exMemMemWrite),
        .i_memToReg     (exMemMemToReg),
        .i_regWrite     (exMemRegWrite),
        .o_branchTaken  (branchTaken),
        .o_branchTarget (branchTarget),
        .o_wbValid      (o_wbValid),
        .o_wbReg        (o_wbReg),
        .o_wbData       (o_wbData)
    );

endmodule

//--- tb/pipelineCpuTb.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module pipelineCpuTb;

    localparam int IMEM_AW        = $clog2(`CPU_IMEM_DEPTH);
    localparam int RESET_CYCLES   = 16;
    localparam int DRAIN_CYCLES   = 8;
    localparam int PIPE_DEPTH     = 5;
    localparam int LEN_ARITH      = 11;
    localparam int LEN_SIGN_EXT   = 4;
    localparam int LEN_MEMORY     = 9;
    localparam int LEN_BRANCH     = 16;
    localparam int LEN_REG_ZERO   = 4;
    localparam int LEN_RESET      = 1;
    localparam int NUM_TESTS      = 6;
    localparam int TOTAL_PROG_LEN = LEN_ARITH + LEN_SIGN_EXT + LEN_MEMORY + LEN_BRANCH
                                    + LEN_REG_ZERO + LEN_RESET;
    localparam int CYCLE_LIMIT    = TOTAL_PROG_LEN + 20 * NUM_TESTS;

    logic                        i_clk;
    logic                        i_reset;
    logic                        i_imemWrite;
    logic [IMEM_AW-1:0]          i_imemAddr;
    isaPkg::instr_t              i_imemData;
    logic                        o_wbValid;
    logic [`CPU_REG_ADDR_W-1:0]  o_wbReg;
    logic [`CPU_DATA_W-1:0]      o_wbData;

    // Program under test and the writes it must produce
    isaPkg::instr_t              progQ[$];
    logic [`CPU_REG_ADDR_W-1:0]  expRegQ[$];
    logic [`CPU_DATA_W-1:0]      expDataQ[$];
    // Writes seen at the writeback port
    logic [`CPU_REG_ADDR_W-1:0]  wbRegQ[$];
    logic [`CPU_DATA_W-1:0]      wbDataQ[$];

    int resetSamples = 0;
    int relCount     = 0;
    int runCycles    = 0;
    int firstWriteAt = 0;

    pipelineCpu DUT (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_imemWrite (i_imemWrite),
        .i_imemAddr  (i_imemAddr),
        .i_imemData  (i_imemData),
        .o_wbValid   (o_wbValid),
        .o_wbReg     (o_wbReg),
        .o_wbData    (o_wbData)
    );

    always #4 i_clk = ~i_clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Monitor and timeout
    ////////////////////////////////////////
    always @(posedge i_clk) begin
        if (i_reset) begin
            resetSamples++;
            relCount = 0;
            // First sample still shows the previous run
            if (resetSamples >= 2 && o_wbValid !== 1'b0) begin
                failRun("o_wbValid was not low while the core was held in reset");
            end
        end else begin
            resetSamples = 0;
            relCount++;
            runCycles++;
            if (runCycles > CYCLE_LIMIT) begin
                failRun($sformatf("Timeout after %0d running cycles", runCycles));
            end
            if (relCount < PIPE_DEPTH && o_wbValid !== 1'b0) begin
                failRun("o_wbValid rose before the first instruction reached writeback");
            end
            if (o_wbValid === 1'b1) begin
                if (wbRegQ.size() == 0) begin
                    firstWriteAt = relCount;
                end
                wbRegQ.push_back(o_wbReg);
                wbDataQ.push_back(o_wbData);
            end
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic checkRegWrite(input int idx, input logic [`CPU_REG_ADDR_W-1:0] expReg,
                                 input logic [`CPU_DATA_W-1:0] expData);
        if (wbRegQ[idx] !== expReg) begin
            $display("** Error: o_wbReg (write %0d) = 0x%h, expected 0x%h",
                     idx, wbRegQ[idx], expReg);
            failRun("Register index mismatch at writeback");
        end
        if (wbDataQ[idx] !== expData) begin
            $display("** Error: o_wbData (write %0d) = 0x%h, expected 0x%h",
                     idx, wbDataQ[idx], expData);
            failRun("Register data mismatch at writeback");
        end
    endtask

    task automatic checkCount(input string what, input int got, input int expVal);
        if (got != expVal) begin
            $display("** Error: %s = 0x%h, expected 0x%h", what, got, expVal);
            failRun("Count mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Encoding and expectation helpers
    ////////////////////////////////////////
    function automatic isaPkg::instr_t rInstr(input isaPkg::funct_t fn, input int rd,
                                              input int rs, input int rt, input int shamt);
        isaPkg::instr_t w;
        w         = isaPkg::NOP;
        w.r.rs    = `CPU_REG_ADDR_W'(rs);
        w.r.rt    = `CPU_REG_ADDR_W'(rt);
        w.r.rd    = `CPU_REG_ADDR_W'(rd);
        w.r.shamt = `CPU_REG_ADDR_W'(shamt);
        w.r.funct = fn;
        return w;
    endfunction

    // Assembly order: op rt, rs, imm
    function automatic isaPkg::instr_t iInstr(input isaPkg::opcode_t op, input int rt,
                                              input int rs, input int imm);
        isaPkg::instr_t w;
        w.i.opcode = op;
        w.i.rs     = `CPU_REG_ADDR_W'(rs);
        w.i.rt     = `CPU_REG_ADDR_W'(rt);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    function automatic logic [`CPU_DATA_W-1:0] signExtend(input logic [15:0] imm);
        int value;
        value = $signed(imm);
        return value;
    endfunction

    task automatic expectWrite(input int regIdx, input logic [`CPU_DATA_W-1:0] data);
        expRegQ.push_back(`CPU_REG_ADDR_W'(regIdx));
        expDataQ.push_back(data);
    endtask

    // Load runs entirely inside the 16 reset cycles, unused slots get NOP
    task automatic loadProgram();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge i_clk);
            i_reset     <= 1'b1;
            i_imemWrite <= 1'b1;
            i_imemAddr  <= IMEM_AW'(i);
            i_imemData  <= (i < progQ.size()) ? progQ[i] : isaPkg::NOP;
        end
        wbRegQ.delete();
        wbDataQ.delete();
        firstWriteAt = 0;
        @(posedge i_clk);
        i_reset     <= 1'b0;
        i_imemWrite <= 1'b0;
    endtask

    task automatic runProgram(input int expLen);
        if (progQ.size() != expLen || expLen > RESET_CYCLES) begin
            failRun($sformatf("Program holds %0d words instead of %0d", progQ.size(), expLen));
        end
        loadProgram();
        while (wbRegQ.size() < expRegQ.size()) begin
            @(posedge i_clk);
        end
        // Extra writes would show up here
        repeat (DRAIN_CYCLES) @(posedge i_clk);
        checkCount("write count", wbRegQ.size(), expRegQ.size());
        foreach (expRegQ[k]) begin
            checkRegWrite(k, expRegQ[k], expDataQ[k]);
        end
        progQ.delete();
        expRegQ.delete();
        expDataQ.delete();
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic testArith();
        logic [15:0]            immA;
        logic [15:0]            immB;
        int                     sh;
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] b;
        immA = 16'($urandom);
        immB = 16'($urandom);
        sh   = int'($urandom_range(31, 0));
        a    = signExtend(immA);
        b    = signExtend(immB);
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 1, 0, immA));
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 2, 0, immB));
        repeat (3) progQ.push_back(isaPkg::NOP);
        progQ.push_back(rInstr(isaPkg::FN_ADD, 3, 1, 2, 0));
        progQ.push_back(rInstr(isaPkg::FN_SUB, 4, 1, 2, 0));
        progQ.push_back(rInstr(isaPkg::FN_AND, 5, 1, 2, 0));
        progQ.push_back(rInstr(isaPkg::FN_OR, 6, 1, 2, 0));
        progQ.push_back(rInstr(isaPkg::FN_SLT, 7, 1, 2, 0));
        progQ.push_back(rInstr(isaPkg::FN_SLL, 8, 0, 2, sh));
        expectWrite(1, a);
        expectWrite(2, b);
        expectWrite(3, a + b);
        expectWrite(4, a - b);
        expectWrite(5, a & b);
        expectWrite(6, a | b);
        expectWrite(7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expectWrite(8, b << sh);
        runProgram(LEN_ARITH);
    endtask

    task automatic testSignExt();
        logic [15:0] pos;
        logic [15:0] neg;
        logic [15:0] neg2;
        pos  = 16'($urandom_range(32767, 0));
        neg  = 16'h8000 | 16'($urandom);
        neg2 = 16'h8000 | 16'($urandom);
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 9, 0, pos));
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 11, 0, neg2));
        progQ.push_back(isaPkg::NOP);
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 10, 9, neg));
        expectWrite(9, signExtend(pos));
        expectWrite(11, signExtend(neg2));
        expectWrite(10, signExtend(pos) + signExtend(neg));
        runProgram(LEN_SIGN_EXT);
    endtask

    task automatic testMemory();
        logic [15:0] valA;
        logic [15:0] valB;
        int          addrA;
        int          addrB;
        valA  = 16'($urandom);
        valB  = 16'($urandom);
        addrA = int'($urandom_range(127, 0)) * 4;
        addrB = addrA + 512;
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 1, 0, valA));
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 2, 0, valB));
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 3, 0, addrA));
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 4, 0, addrB));
        progQ.push_back(isaPkg::NOP);
        progQ.push_back(iInstr(isaPkg::OP_SW, 1, 3, 0));
        progQ.push_back(iInstr(isaPkg::OP_SW, 2, 4, 0));
        progQ.push_back(iInstr(isaPkg::OP_LW, 5, 3, 0));
        progQ.push_back(iInstr(isaPkg::OP_LW, 6, 4, 0));
        expectWrite(1, signExtend(valA));
        expectWrite(2, signExtend(valB));
        expectWrite(3, addrA);
        expectWrite(4, addrB);
        expectWrite(5, signExtend(valA));
        expectWrite(6, signExtend(valB));
        runProgram(LEN_MEMORY);
    endtask

    // Taken beq at word 4 lands on word 10, untaken beq at word 11
    task automatic testBranch();
        logic [15:0] v;
        v = 16'($urandom) | 16'h0001;
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 1, 0, v));
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 2, 0, v));
        repeat (2) progQ.push_back(isaPkg::NOP);
        progQ.push_back(iInstr(isaPkg::OP_BEQ, 2, 1, 5));
        for (int k = 0; k < 5; k++) begin
            progQ.push_back(iInstr(isaPkg::OP_ADDI, 3 + k, 0, k + 1));
        end
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 8, 0, 6));
        progQ.push_back(iInstr(isaPkg::OP_BEQ, 0, 1, 2));
        for (int k = 0; k < 4; k++) begin
            progQ.push_back(iInstr(isaPkg::OP_ADDI, 9 + k, 0, 7 + k));
        end
        expectWrite(1, signExtend(v));
        expectWrite(2, signExtend(v));
        expectWrite(3, 1);
        expectWrite(4, 2);
        expectWrite(5, 3);
        expectWrite(8, 6);
        for (int k = 0; k < 4; k++) begin
            expectWrite(9 + k, 7 + k);
        end
        runProgram(LEN_BRANCH);
    endtask

    task automatic testRegZero();
        logic [15:0] v;
        v = 16'($urandom) | 16'h0001;
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 0, 0, v));
        repeat (2) progQ.push_back(isaPkg::NOP);
        progQ.push_back(rInstr(isaPkg::FN_ADD, 13, 0, 0, 0));
        // The write is reported but r0 still reads zero
        expectWrite(0, signExtend(v));
        expectWrite(13, 0);
        runProgram(LEN_REG_ZERO);
    endtask

    task automatic testReset();
        logic [15:0] v;
        v = 16'($urandom);
        progQ.push_back(iInstr(isaPkg::OP_ADDI, 15, 0, v));
        expectWrite(15, signExtend(v));
        runProgram(LEN_RESET);
        checkCount("first write cycle", firstWriteAt, PIPE_DEPTH);
    endtask

    initial begin
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_imemWrite = 1'b0;
        i_imemAddr  = '0;
        i_imemData  = isaPkg::NOP;
        void'($urandom(32'hca45));
        testReset();
        testArith();
        testSignExt();
        testMemory();
        testBranch();
        testRegZero();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- pipelineCpu.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/controlUnit.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/pipelineCpu.sv
tb/pipelineCpuTb.sv

//--- Bender.yml
package:
  name: pipeline_cpu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isaPkg.sv
      - verilog/pipePkg.sv
      - verilog/controlUnit.sv
      - verilog/fetchStage.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/memWbStage.sv
      - verilog/pipelineCpu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/pipelineCpuTb.sv
